//--- list.f
+incdir+testbench
verilog/cce_inst_pkg.sv
verilog/cce_msg_pkg.sv
verilog/cce_decoded_if.sv
verilog/cce_pending.sv
verilog/cce_inst_fetch.sv
verilog/cce_inst_decode.sv
verilog/cce_exec.sv
verilog/cce_cmd_out.sv
verilog/cce_top.sv
testbench/tb_cce.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build tb_cce with Verilator, run it and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module tb_cce -Mdir obj_dir
	./obj_dir/Vtb_cce | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_cce_programs.svh
/* Program table. Each row holds up to 16 words ending in a self-jump and the commands
   it must emit in order. Rows past num_progs rerun the same programs with random ready. */
`ifndef TB_CCE_PROGRAMS_SVH
`define TB_CCE_PROGRAMS_SVH

localparam int num_progs = 4;
localparam int num_rows  = 2 * num_progs;
localparam int max_words = 16;
localparam int max_cmds  = 8;

logic [31:0] prog_words [num_rows][max_words];
int          prog_len [num_rows];
bit          ready_random [num_rows];
int          exp_count [num_rows];
logic [1:0]  exp_type [num_rows][max_cmds];
logic [1:0]  exp_lce [num_rows][max_cmds];
logic [31:0] exp_addr [num_rows][max_cmds];

// Fields from the top: opcode, dst, src_a, src_b, spare, imm
function automatic logic [31:0] encode_inst(input cce_inst_pkg::cce_opcode_e op,
                                            input int dst, input int a,
                                            input int b, input int imm);
  return {op, 3'(dst), 3'(a), 3'(b), 3'b000, 16'(imm)};
endfunction

task automatic add_word(input int row, input logic [31:0] word);
  prog_words[row][prog_len[row]] = word;
  prog_len[row] = prog_len[row] + 1;
endtask

task automatic add_expected(input int row, input logic [1:0] typ, input logic [1:0] lce,
                            input logic [31:0] addr);
  exp_type[row][exp_count[row]] = typ;
  exp_lce[row][exp_count[row]]  = lce;
  exp_addr[row][exp_count[row]] = addr;
  exp_count[row] = exp_count[row] + 1;
endtask

task automatic build_programs();
  for (int r = 0; r < num_rows; r++) begin
    prog_len[r]     = 0;
    exp_count[r]    = 0;
    ready_random[r] = (r >= num_progs);
  end

  // ALU results as send addresses, operands chosen so add carries and sub borrows
  add_word(0, encode_inst(cce_inst_pkg::e_op_movi, 1, 0, 0, 'h111));
  add_word(0, encode_inst(cce_inst_pkg::e_op_movi, 2, 0, 0, 'h23));
  add_word(0, encode_inst(cce_inst_pkg::e_op_add, 3, 1, 2, 0));
  add_word(0, encode_inst(cce_inst_pkg::e_op_movi, 4, 0, 0, 2));
  add_word(0, encode_inst(cce_inst_pkg::e_op_send, 0, 4, 3, cce_msg_pkg::e_cmd_set_state));
  add_word(0, encode_inst(cce_inst_pkg::e_op_sub, 5, 3, 2, 0));
  add_word(0, encode_inst(cce_inst_pkg::e_op_movi, 6, 0, 0, 3));
  add_word(0, encode_inst(cce_inst_pkg::e_op_send, 0, 6, 5, cce_msg_pkg::e_cmd_transfer));
  add_word(0, encode_inst(cce_inst_pkg::e_op_movi, 7, 0, 0, 'hff0));
  add_word(0, encode_inst(cce_inst_pkg::e_op_and, 5, 3, 7, 0));
  add_word(0, encode_inst(cce_inst_pkg::e_op_send, 0, 1, 5, cce_msg_pkg::e_cmd_writeback));
  add_word(0, encode_inst(cce_inst_pkg::e_op_jmp, 0, 0, 0, 11));
  add_expected(0, cce_msg_pkg::e_cmd_set_state, 2, 'h134);
  add_expected(0, cce_msg_pkg::e_cmd_transfer, 3, 'h111);
  add_expected(0, cce_msg_pkg::e_cmd_writeback, 1, 'h130);

  // Count 0..2 with bne, then one closing send
  add_word(1, encode_inst(cce_inst_pkg::e_op_movi, 1, 0, 0, 0));
  add_word(1, encode_inst(cce_inst_pkg::e_op_movi, 2, 0, 0, 1));
  add_word(1, encode_inst(cce_inst_pkg::e_op_movi, 3, 0, 0, 3));
  add_word(1, encode_inst(cce_inst_pkg::e_op_movi, 4, 0, 0, 1));
  add_word(1, encode_inst(cce_inst_pkg::e_op_send, 0, 4, 1, cce_msg_pkg::e_cmd_inv));
  add_word(1, encode_inst(cce_inst_pkg::e_op_add, 1, 1, 2, 0));
  add_word(1, encode_inst(cce_inst_pkg::e_op_bne, 0, 1, 3, 4));
  add_word(1, encode_inst(cce_inst_pkg::e_op_send, 0, 2, 3, cce_msg_pkg::e_cmd_writeback));
  add_word(1, encode_inst(cce_inst_pkg::e_op_jmp, 0, 0, 0, 8));
  for (int i = 0; i < 3; i++) begin
    add_expected(1, cce_msg_pkg::e_cmd_inv, 1, i);
  end
  add_expected(1, cce_msg_pkg::e_cmd_writeback, 1, 3);

  // Address walk 0x40..0x60, exit on beq, loop back with jmp
  add_word(2, encode_inst(cce_inst_pkg::e_op_movi, 1, 0, 0, 'h40));
  add_word(2, encode_inst(cce_inst_pkg::e_op_movi, 2, 0, 0, 'h10));
  add_word(2, encode_inst(cce_inst_pkg::e_op_movi, 3, 0, 0, 'h70));
  add_word(2, encode_inst(cce_inst_pkg::e_op_movi, 5, 0, 0, 2));
  add_word(2, encode_inst(cce_inst_pkg::e_op_beq, 0, 1, 3, 8));
  add_word(2, encode_inst(cce_inst_pkg::e_op_send, 0, 5, 1, cce_msg_pkg::e_cmd_transfer));
  add_word(2, encode_inst(cce_inst_pkg::e_op_add, 1, 1, 2, 0));
  add_word(2, encode_inst(cce_inst_pkg::e_op_jmp, 0, 0, 0, 4));
  add_word(2, encode_inst(cce_inst_pkg::e_op_jmp, 0, 0, 0, 8));
  add_expected(2, cce_msg_pkg::e_cmd_transfer, 2, 'h40);
  add_expected(2, cce_msg_pkg::e_cmd_transfer, 2, 'h50);
  add_expected(2, cce_msg_pkg::e_cmd_transfer, 2, 'h60);

  // Pending bits of groups 5 and 9 set, group 12 untouched
  add_word(3, encode_inst(cce_inst_pkg::e_op_movi, 1, 0, 0, 5));
  add_word(3, encode_inst(cce_inst_pkg::e_op_movi, 2, 0, 0, 9));
  add_word(3, encode_inst(cce_inst_pkg::e_op_movi, 3, 0, 0, 12));
  add_word(3, encode_inst(cce_inst_pkg::e_op_wdp, 0, 1, 0, 1));
  add_word(3, encode_inst(cce_inst_pkg::e_op_wdp, 0, 2, 0, 1));
  add_word(3, encode_inst(cce_inst_pkg::e_op_rdp, 4, 1, 0, 0));
  add_word(3, encode_inst(cce_inst_pkg::e_op_rdp, 5, 3, 0, 0));
  add_word(3, encode_inst(cce_inst_pkg::e_op_rdp, 6, 2, 0, 0));
  add_word(3, encode_inst(cce_inst_pkg::e_op_send, 0, 0, 4, cce_msg_pkg::e_cmd_inv));
  add_word(3, encode_inst(cce_inst_pkg::e_op_send, 0, 0, 5, cce_msg_pkg::e_cmd_inv));
  add_word(3, encode_inst(cce_inst_pkg::e_op_send, 0, 0, 6, cce_msg_pkg::e_cmd_set_state));
  add_word(3, encode_inst(cce_inst_pkg::e_op_jmp, 0, 0, 0, 11));
  add_expected(3, cce_msg_pkg::e_cmd_inv, 0, 1);
  add_expected(3, cce_msg_pkg::e_cmd_inv, 0, 0);
  add_expected(3, cce_msg_pkg::e_cmd_set_state, 0, 1);

  // Same programs and results under random ready
  for (int r = 0; r < num_progs; r++) begin
    prog_len[r + num_progs]  = prog_len[r];
    exp_count[r + num_progs] = exp_count[r];
    for (int i = 0; i < max_words; i++) begin
      prog_words[r + num_progs][i] = prog_words[r][i];
    end
    for (int i = 0; i < max_cmds; i++) begin
      exp_type[r + num_progs][i] = exp_type[r][i];
      exp_lce[r + num_progs][i]  = exp_lce[r][i];
      exp_addr[r + num_progs][i] = exp_addr[r][i];
    end
  end
endtask

`endif

//--- testbench/tb_cce.sv
/* Loads each program of the table through config, runs it and compares the handshaked
   LCE commands with the expected list. Ready is held high or driven at random. */
`timescale 1ns/1ps
`default_nettype none

module tb_cce;

  logic                                     clk_i;
  logic                                     rst_i;
  logic                                     cfg_w_v_i;
  logic [cce_msg_pkg::cfg_addr_width-1:0]   cfg_addr_i;
  logic [cce_msg_pkg::cfg_data_width-1:0]   cfg_data_i;
  logic                                     lce_cmd_v_o;
  logic                                     lce_cmd_ready_i;
  cce_msg_pkg::lce_cmd_type_e               lce_cmd_type_o;
  logic [1:0]                               lce_cmd_lce_o;
  logic [cce_msg_pkg::lce_addr_width-1:0]   lce_cmd_addr_o;

  integer seed;
  int     checks;
  int     errors;
  int     cycle_count = 0;
  int     timeout_limit = 0;

  `include "tb_cce_programs.svh"

  cce_top
    #(.inst_ram_els(32)
      ,.num_way_groups(16)
      ,.num_lce(4)
      )
    cce_top_inst
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cfg_w_v_i(cfg_w_v_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_data_i(cfg_data_i)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.lce_cmd_type_o(lce_cmd_type_o)
      ,.lce_cmd_lce_o(lce_cmd_lce_o)
      ,.lce_cmd_addr_o(lce_cmd_addr_o)
      );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic reset_dut();
    @(posedge clk_i);
    rst_i           <= 1'b1;
    cfg_w_v_i       <= 1'b0;
    lce_cmd_ready_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  task automatic drive_ready(input int row);
    logic [31:0] rnd;
    if (ready_random[row]) begin
      rnd = $random(seed);
      lce_cmd_ready_i <= rnd[0];
    end else begin
      lce_cmd_ready_i <= 1'b1;
    end
  endtask

  // No command may leave while in load mode
  task automatic check_idle();
    checks++;
    assert (!lce_cmd_v_o) else begin
      $display("lce_cmd_v_o went high at %0t before the engine was started", $time);
      errors++;
    end
  endtask

  task automatic load_program(input int row);
    for (int i = 0; i < prog_len[row]; i++) begin
      @(negedge clk_i);
      check_idle();
      @(posedge clk_i);
      cfg_w_v_i  <= 1'b1;
      cfg_addr_i <= 16'(i);
      cfg_data_i <= prog_words[row][i];
    end
    @(negedge clk_i);
    check_idle();
    @(posedge clk_i);
    cfg_addr_i <= cce_msg_pkg::cfg_mode_addr;
    cfg_data_i <= 32'(cce_msg_pkg::e_mode_run);
    @(posedge clk_i);
    cfg_w_v_i <= 1'b0;
    drive_ready(row);
  endtask

  task automatic check_command(input int row, input int idx);
    checks += 3;
    assert (lce_cmd_type_o == exp_type[row][idx]) else begin
      $display("MISMATCH at %0t: lce_cmd_type_o expected %0d got %0d",
               $time, exp_type[row][idx], lce_cmd_type_o);
      errors++;
    end
    assert (lce_cmd_lce_o == exp_lce[row][idx]) else begin
      $display("MISMATCH at %0t: lce_cmd_lce_o expected %0d got %0d",
               $time, exp_lce[row][idx], lce_cmd_lce_o);
      errors++;
    end
    assert (lce_cmd_addr_o == exp_addr[row][idx]) else begin
      $display("MISMATCH at %0t: lce_cmd_addr_o expected 0x%h got 0x%h",
               $time, exp_addr[row][idx], lce_cmd_addr_o);
      errors++;
    end
  endtask

  // Handshakes are sampled mid-cycle, ahead of the edge that completes them
  task automatic collect_commands(input int row);
    int n;
    n = 0;
    while (n < exp_count[row]) begin
      @(negedge clk_i);
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        check_command(row, n);
        n++;
      end
      @(posedge clk_i);
      drive_ready(row);
    end
    repeat (20) begin
      @(negedge clk_i);
      checks++;
      assert (!lce_cmd_v_o) else begin
        $display("extra command at %0t after the last expected one in row %0d", $time, row);
        errors++;
      end
      @(posedge clk_i);
      drive_ready(row);
    end
  endtask

  initial begin
    int row_errors;
    seed            = 6;
    rst_i           = 1'b1;
    cfg_w_v_i       = 1'b0;
    cfg_addr_i      = '0;
    cfg_data_i      = '0;
    lce_cmd_ready_i = 1'b0;
    checks          = 0;
    errors          = 0;
    build_programs();
    for (int r = 0; r < num_rows; r++) begin
      timeout_limit += (prog_len[r] + 10 * exp_count[r]) * 4;
    end

    for (int r = 0; r < num_rows; r++) begin
      row_errors = errors;
      reset_dut();
      load_program(r);
      collect_commands(r);
      $display("row %0d (%s ready): %0d commands, %0d errors", r,
               ready_random[r] ? "random" : "steady", exp_count[r], errors - row_errors);
    end

    $display("%0d rows, %0d checks, %0d errors", num_rows, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cce_top.sv
/* Programmable coherence engine. Load the instruction RAM through config, then
   write the mode address to run. Commands leave on a ready/valid port. */
`timescale 1ns/1ps
`default_nettype none

module cce_top
  #(parameter int inst_ram_els   = 32
    , parameter int num_way_groups = 16
    , parameter int num_lce        = 4
    , localparam int pc_width      = $clog2(inst_ram_els)
    , localparam int lg_num_lce    = $clog2(num_lce)
  )
  (input  logic                                       clk_i
   , input  logic                                     rst_i

   // Config channel
   , input  logic                                     cfg_w_v_i
   , input  logic [cce_msg_pkg::cfg_addr_width-1:0]   cfg_addr_i
   , input  logic [cce_msg_pkg::cfg_data_width-1:0]   cfg_data_i

   // LCE command, ready&valid
   , output logic                                     lce_cmd_v_o
   , input  logic                                     lce_cmd_ready_i
   , output cce_msg_pkg::lce_cmd_type_e               lce_cmd_type_o
   , output logic [lg_num_lce-1:0]                    lce_cmd_lce_o
   , output logic [cce_msg_pkg::lce_addr_width-1:0]   lce_cmd_addr_o
  );

  cce_inst_pkg::cce_inst_t                    fetch_inst_lo;
  logic                                       fetch_inst_v_lo;
  logic                                       stall_lo;
  logic                                       branch_v_lo;
  logic [pc_width-1:0]                        branch_target_lo;
  logic [lg_num_lce-1:0]                      send_lce_lo;
  logic [cce_msg_pkg::lce_addr_width-1:0]     send_addr_lo;
  logic                                       cmd_busy_lo;

  cce_decoded_if decoded_if ();

  cce_inst_fetch
    #(.inst_ram_els(inst_ram_els))
    inst_fetch
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cfg_w_v_i(cfg_w_v_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_data_i(cfg_data_i)
      ,.stall_i(stall_lo)
      ,.branch_v_i(branch_v_lo)
      ,.branch_target_i(branch_target_lo)
      ,.inst_o(fetch_inst_lo)
      ,.inst_v_o(fetch_inst_v_lo)
      );

  cce_inst_decode
    inst_decode
     (.inst_i(fetch_inst_lo)
      ,.inst_v_i(fetch_inst_v_lo)
      ,.cmd_busy_i(cmd_busy_lo)
      ,.dec(decoded_if)
      ,.stall_o(stall_lo)
      );

  cce_exec
    #(.inst_ram_els(inst_ram_els)
      ,.num_way_groups(num_way_groups)
      ,.num_lce(num_lce)
      )
    exec
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.exe(decoded_if)
      ,.branch_v_o(branch_v_lo)
      ,.branch_target_o(branch_target_lo)
      ,.send_lce_o(send_lce_lo)
      ,.send_addr_o(send_addr_lo)
      );

  cce_cmd_out
    #(.num_lce(num_lce))
    cmd_out
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.out(decoded_if)
      ,.send_lce_i(send_lce_lo)
      ,.send_addr_i(send_addr_lo)
      ,.cmd_busy_o(cmd_busy_lo)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.lce_cmd_type_o(lce_cmd_type_o)
      ,.lce_cmd_lce_o(lce_cmd_lce_o)
      ,.lce_cmd_addr_o(lce_cmd_addr_o)
      );

endmodule

`default_nettype wire

//--- verilog/cce_cmd_out.sv
/* One-entry LCE command register, ready&valid. A send may refill the register in
   the same cycle the previous command hands off. */
`timescale 1ns/1ps
`default_nettype none

module cce_cmd_out
  #(parameter int num_lce     = 4
    , localparam int lg_num_lce = $clog2(num_lce)
  )
  (input  logic                                       clk_i
   , input  logic                                     rst_i
   , cce_decoded_if.out                               out
   , input  logic [lg_num_lce-1:0]                    send_lce_i
   , input  logic [cce_msg_pkg::lce_addr_width-1:0]   send_addr_i
   , output logic                                     cmd_busy_o
   , output logic                                     lce_cmd_v_o
   , input  logic                                     lce_cmd_ready_i
   , output cce_msg_pkg::lce_cmd_type_e               lce_cmd_type_o
   , output logic [lg_num_lce-1:0]                    lce_cmd_lce_o
   , output logic [cce_msg_pkg::lce_addr_width-1:0]   lce_cmd_addr_o
  );

  logic                                     v_r;
  cce_msg_pkg::lce_cmd_type_e               type_r;
  logic [lg_num_lce-1:0]                    lce_r;
  logic [cce_msg_pkg::lce_addr_width-1:0]   addr_r;
  logic                                     load;

  assign load = out.v & (out.opcode == cce_inst_pkg::e_op_send);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      v_r <= 1'b0;
    end else if (load) begin
      v_r <= 1'b1;
    end else if (lce_cmd_ready_i) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      type_r <= cce_msg_pkg::lce_cmd_type_e'(out.imm[1:0]);
      lce_r  <= send_lce_i;
      addr_r <= send_addr_i;
    end
  end

  // Full and not draining this cycle
  assign cmd_busy_o = v_r & ~lce_cmd_ready_i;

  assign lce_cmd_v_o    = v_r;
  assign lce_cmd_type_o = type_r;
  assign lce_cmd_lce_o  = lce_r;
  assign lce_cmd_addr_o = addr_r;

  // Holds only if decode withholds sends while busy
  a_hold_while_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
    (v_r && !lce_cmd_ready_i) |=> (v_r && $stable(type_r) && $stable(lce_r)
                                   && $stable(addr_r)))
    else $error("LCE command changed while stalled");

endmodule

`default_nettype wire

//--- verilog/cce_exec.sv
/* Register file, ALU and branch resolution. Results are written at the edge that
   ends the decode cycle; way group and LCE come from the low bits of a. */
`timescale 1ns/1ps
`default_nettype none

module cce_exec
  #(parameter int inst_ram_els     = 32
    , parameter int num_way_groups = 16
    , parameter int num_lce        = 4
    , localparam int pc_width      = $clog2(inst_ram_els)
    , localparam int lg_num_wg     = $clog2(num_way_groups)
    , localparam int lg_num_lce    = $clog2(num_lce)
  )
  (input  logic                                       clk_i
   , input  logic                                     rst_i
   , cce_decoded_if.exe                               exe
   , output logic                                     branch_v_o
   , output logic [pc_width-1:0]                      branch_target_o
   , output logic [lg_num_lce-1:0]                    send_lce_o
   , output logic [cce_msg_pkg::lce_addr_width-1:0]   send_addr_o
  );

  localparam int gw = cce_inst_pkg::gpr_width;

  logic [gw-1:0] gpr_r [cce_inst_pkg::num_gpr];

  logic [gw-1:0] opd_a, opd_b, imm_ext, alu_res;
  logic          gpr_w_v, taken;
  logic          pending_w_v, pending_lo;

  assign opd_a   = gpr_r[exe.src_a];
  assign opd_b   = gpr_r[exe.src_b];
  assign imm_ext = {{(gw-cce_inst_pkg::imm_width){1'b0}}, exe.imm};

  always_comb begin
    alu_res = '0;
    gpr_w_v = 1'b0;
    taken   = 1'b0;
    case (exe.opcode)
      cce_inst_pkg::e_op_movi: begin
        alu_res = imm_ext;
        gpr_w_v = 1'b1;
      end
      cce_inst_pkg::e_op_add: begin
        alu_res = opd_a + opd_b;
        gpr_w_v = 1'b1;
      end
      cce_inst_pkg::e_op_sub: begin
        alu_res = opd_a - opd_b;
        gpr_w_v = 1'b1;
      end
      cce_inst_pkg::e_op_and: begin
        alu_res = opd_a & opd_b;
        gpr_w_v = 1'b1;
      end
      cce_inst_pkg::e_op_rdp: begin
        alu_res = {{(gw-1){1'b0}}, pending_lo};
        gpr_w_v = 1'b1;
      end
      cce_inst_pkg::e_op_beq: taken = (opd_a == opd_b);
      cce_inst_pkg::e_op_bne: taken = (opd_a != opd_b);
      cce_inst_pkg::e_op_jmp: taken = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpr_r <= '{default: '0};
    end else if (exe.v && gpr_w_v) begin
      gpr_r[exe.dst] <= alu_res;
    end
  end

  assign branch_v_o      = exe.v & taken;
  assign branch_target_o = exe.imm[pc_width-1:0];

  assign pending_w_v = exe.v & (exe.opcode == cce_inst_pkg::e_op_wdp);

  cce_pending
    #(.num_way_groups(num_way_groups))
    pending_bits
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.w_v_i(pending_w_v)
      ,.w_way_group_i(opd_a[lg_num_wg-1:0])
      ,.pending_i(exe.imm[0])
      ,.r_way_group_i(opd_a[lg_num_wg-1:0])
      ,.pending_o(pending_lo)
      );

  assign send_lce_o  = opd_a[lg_num_lce-1:0];
  assign send_addr_o = opd_b[cce_msg_pkg::lce_addr_width-1:0];

endmodule

`default_nettype wire

//--- verilog/cce_inst_decode.sv
/* Combinational decode. A send that finds the command register busy stalls
   fetch and is withheld from execute until the register frees up. */
`timescale 1ns/1ps
`default_nettype none

module cce_inst_decode
  (input  cce_inst_pkg::cce_inst_t   inst_i
   , input  logic                    inst_v_i
   , input  logic                    cmd_busy_i
   , cce_decoded_if.dec              dec
   , output logic                    stall_o
  );

  logic is_send;

  assign is_send = (inst_i.opcode == cce_inst_pkg::e_op_send);

  // Back-pressure only applies to sends
  assign stall_o = inst_v_i & is_send & cmd_busy_i;

  assign dec.v      = inst_v_i & ~stall_o;
  assign dec.opcode = inst_i.opcode;
  assign dec.dst    = inst_i.dst;
  assign dec.src_a  = inst_i.src_a;
  assign dec.src_b  = inst_i.src_b;
  assign dec.imm    = inst_i.imm;

  // Words loaded through config are not range checked elsewhere
  always_comb begin
    if (inst_v_i) begin
      a_known_opcode: assert final (inst_i.opcode inside
        {[cce_inst_pkg::e_op_movi : cce_inst_pkg::e_op_nop]})
        else $error("undefined opcode %0d", inst_i.opcode);
    end
  end

endmodule

`default_nettype wire

//--- verilog/cce_inst_fetch.sv
/* Mode register, instruction RAM and PC. The RAM is only written in load mode;
   a taken branch kills the one word fetched behind it. */
`timescale 1ns/1ps
`default_nettype none

module cce_inst_fetch
  #(parameter int inst_ram_els = 32
    , localparam int pc_width  = $clog2(inst_ram_els)
  )
  (input  logic                                       clk_i
   , input  logic                                     rst_i
   , input  logic                                     cfg_w_v_i
   , input  logic [cce_msg_pkg::cfg_addr_width-1:0]   cfg_addr_i
   , input  logic [cce_msg_pkg::cfg_data_width-1:0]   cfg_data_i
   , input  logic                                     stall_i
   , input  logic                                     branch_v_i
   , input  logic [pc_width-1:0]                      branch_target_i
   , output cce_inst_pkg::cce_inst_t                  inst_o
   , output logic                                     inst_v_o
  );

  logic [cce_inst_pkg::inst_width-1:0] ram [inst_ram_els];

  cce_msg_pkg::cce_mode_e    mode_r;
  logic [pc_width-1:0]       pc_r;
  cce_inst_pkg::cce_inst_t   inst_r;
  logic                      inst_v_r;

  logic ram_w_v, mode_w_v, fetch_en;

  // Bit 15 clear selects the RAM
  assign ram_w_v  = cfg_w_v_i & ~cfg_addr_i[cce_msg_pkg::cfg_addr_width-1];
  assign mode_w_v = cfg_w_v_i & (cfg_addr_i == cce_msg_pkg::cfg_mode_addr);
  assign fetch_en = (mode_r == cce_msg_pkg::e_mode_run) & ~stall_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_r   <= cce_msg_pkg::e_mode_load;
      pc_r     <= '0;
      inst_v_r <= 1'b0;
    end else begin
      if (mode_w_v) begin
        mode_r <= cce_msg_pkg::cce_mode_e'(cfg_data_i[0]);
      end
      if (fetch_en) begin
        if (branch_v_i) begin
          pc_r     <= branch_target_i;
          inst_v_r <= 1'b0;
        end else begin
          pc_r     <= pc_r + 1'b1;
          inst_v_r <= 1'b1;
        end
      end else if (mode_r != cce_msg_pkg::e_mode_run) begin
        inst_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ram_w_v) begin
      ram[cfg_addr_i[pc_width-1:0]] <= cfg_data_i[cce_inst_pkg::inst_width-1:0];
    end
    if (fetch_en && !branch_v_i) begin
      inst_r <= cce_inst_pkg::cce_inst_t'(ram[pc_r]);
    end
  end

  assign inst_o   = inst_r;
  assign inst_v_o = inst_v_r;

  // Program must be fully loaded before the mode switch
  a_no_ram_write_in_run: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ram_w_v && mode_r == cce_msg_pkg::e_mode_run))
    else $error("instruction RAM written in run mode");

endmodule

`default_nettype wire

//--- verilog/cce_pending.sv
/* One pending bit per way group, cleared on reset. Write is synchronous and the
   read is combinational, so a read in the write cycle returns the old bit. */
`timescale 1ns/1ps
`default_nettype none

module cce_pending
  #(parameter int num_way_groups = 16
    , localparam int lg_num_wg   = $clog2(num_way_groups)
  )
  (input  logic                    clk_i
   , input  logic                  rst_i
   , input  logic                  w_v_i
   , input  logic [lg_num_wg-1:0]  w_way_group_i
   , input  logic                  pending_i
   , input  logic [lg_num_wg-1:0]  r_way_group_i
   , output logic                  pending_o
  );

  logic [num_way_groups-1:0] bits_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bits_r <= '0;
    end else if (w_v_i) begin
      bits_r[w_way_group_i] <= pending_i;
    end
  end

  assign pending_o = bits_r[r_way_group_i];

endmodule

`default_nettype wire

//--- verilog/cce_decoded_if.sv
/* One decoded instruction, valid for a single cycle. v stays low while decode
   stalls, so no consumer sees an instruction twice. */
`timescale 1ns/1ps
`default_nettype none

interface cce_decoded_if;

  logic                                 v;
  cce_inst_pkg::cce_opcode_e            opcode;
  cce_inst_pkg::gpr_idx_t               dst;
  cce_inst_pkg::gpr_idx_t               src_a;
  cce_inst_pkg::gpr_idx_t               src_b;
  logic [cce_inst_pkg::imm_width-1:0]   imm;

  modport dec (output v, output opcode, output dst, output src_a, output src_b, output imm);

  modport exe (input v, input opcode, input dst, input src_a, input src_b, input imm);

  // Command sender only needs the opcode and the type bits of imm
  modport out (input v, input opcode, input imm);

endinterface

`default_nettype wire

//--- verilog/cce_msg_pkg.sv
/* Configuration address map and LCE command types. Config addresses with bit 15
   clear select the instruction RAM, and the mode register sits at 16'h8000. */
`default_nettype none

package cce_msg_pkg;

  localparam int cfg_addr_width = 16;
  localparam int cfg_data_width = 32;

  localparam logic [cfg_addr_width-1:0] cfg_mode_addr = 16'h8000;

  typedef enum logic {
    e_mode_load,
    e_mode_run
  } cce_mode_e;

  typedef enum logic [1:0] {
    e_cmd_inv,
    e_cmd_set_state,
    e_cmd_transfer,
    e_cmd_writeback
  } lce_cmd_type_e;

  localparam int lce_addr_width = 32;

endpackage

`default_nettype wire

//--- verilog/cce_inst_pkg.sv
/* Microcode instruction format of the engine. Immediates are zero-extended to the
   register width, and a branch target is taken from the low bits of imm. */
`default_nettype none

package cce_inst_pkg;

  localparam int inst_width = 32;
  localparam int gpr_width  = 32;
  localparam int num_gpr    = 8;
  localparam int imm_width  = 16;

  typedef logic [2:0] gpr_idx_t;

  // Encodings are contiguous from movi to nop
  typedef enum logic [3:0] {
    e_op_movi,
    e_op_add,
    e_op_sub,
    e_op_and,
    e_op_beq,
    e_op_bne,
    e_op_jmp,
    e_op_wdp,
    e_op_rdp,
    e_op_send,
    e_op_nop
  } cce_opcode_e;

  typedef struct packed {
    cce_opcode_e           opcode;
    gpr_idx_t              dst;
    gpr_idx_t              src_a;
    gpr_idx_t              src_b;
    logic [2:0]            spare;
    logic [imm_width-1:0]  imm;
  } cce_inst_t;

endpackage

`default_nettype wire
